// ==== verilog/jisp_pixel_pkg.sv ====
//////////////////////////////////////////////////
// Pixel level definitions for the JPEG ISP.
// Holds sample types and the RGB to YCbCr matrix.
//////////////////////////////////////////////////
`default_nettype none

package jisp_pixel_pkg;

    // sample width in bits.
    localparam int DW = 8;

    typedef logic [DW-1:0] sample_t;

    // three samples, R/G/B or Y/Cb/Cr.
    typedef sample_t [2:0] pixel_t;

    // component indices on the YCbCr side.
    localparam int CH_Y  = 0;
    localparam int CH_CB = 1;
    localparam int CH_CR = 2;

    typedef logic signed [8:0] coef_t;

    // JPEG matrix scaled by 256, one row per output channel.
    localparam coef_t COEF [3][3] = '{
        '{ 9'sd77,   9'sd150,  9'sd29 },
        '{-9'sd43,  -9'sd85,   9'sd128},
        '{ 9'sd128, -9'sd107, -9'sd21 }
    };

    // chroma is centred on mid scale.
    localparam int CH_OFFSET [3] = '{0, 128, 128};

endpackage

`default_nettype wire

// ==== verilog/jisp_frame_pkg.sv ====
//////////////////////////////////////////////////
// Frame geometry and MCU layout constants.
// Shared by the line counters and the MCU buffer.
//////////////////////////////////////////////////
`default_nettype none

package jisp_frame_pkg;

    localparam int MAX_X = 1280;
    localparam int MAX_Y = 720;
    localparam int X_W   = $clog2(MAX_X);
    localparam int Y_W   = $clog2(MAX_Y);

    localparam int MCU_SIZE       = 16;
    localparam int BLK_SIZE       = 8;
    localparam int BLOCKS_PER_MCU = 6;

    localparam int MCU_LOG = $clog2(MCU_SIZE);
    localparam int BLK_LOG = $clog2(BLK_SIZE);

    // buffer word addresses, one word is a block row.
    localparam int Y_ADDR_W  = MCU_LOG + X_W - BLK_LOG;
    localparam int C_ADDR_W  = BLK_LOG + X_W - MCU_LOG;
    localparam int MCU_COL_W = X_W - MCU_LOG;

endpackage

`default_nettype wire

// ==== verilog/pixel_stream_if.sv ====
//////////////////////////////////////////////////
// Valid/hold pixel stream between ISP stages.
// The source drives all but hold. A lane moves
// on a clock edge where its bit is set and hold
// is low.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface pixel_stream_if #(
    parameter type payload_t = logic [23:0]
);
    payload_t   data;
    // one valid bit per component.
    logic [2:0] lanes;
    logic       hold;
    logic       frame_valid;
    logic       line_valid;
    logic       eof;

    modport src (
        output data, lanes, frame_valid, line_valid, eof,
        input  hold
    );

    modport snk (
        input  data, lanes, frame_valid, line_valid, eof,
        output hold
    );
endinterface

`default_nettype wire

// ==== verilog/color_matrix_row.sv ====
//////////////////////////////////////////////////
// One output channel of the RGB to YCbCr matrix.
// Two pipeline stages, both advance on en.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module color_matrix_row #(
    parameter int CHANNEL = 0
)(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    en,
    input  jisp_pixel_pkg::pixel_t  rgb,
    output jisp_pixel_pkg::sample_t result
);
    import jisp_pixel_pkg::*;

    logic signed [17:0] prod [3];
    logic signed [19:0] sum;
    logic signed [19:0] level;

    // floor divide by 256, then centre the chroma.
    assign sum   = prod[0] + prod[1] + prod[2];
    assign level = (sum >>> 8) + 20'(CH_OFFSET[CHANNEL]);

    // stage 1: products.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 3; i++) begin
                prod[i] <= '0;
            end
        end else if (en) begin
            for (int i = 0; i < 3; i++) begin
                prod[i] <= $signed({1'b0, rgb[i]}) * COEF[CHANNEL][i];
            end
        end
    end

    // stage 2: sum and clamp to 0..255.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (en) begin
            if (level < 0) begin
                result <= '0;
            end else if (level > 20'sd255) begin
                result <= '1;
            end else begin
                result <= level[DW-1:0];
            end
        end
    end
endmodule

`default_nettype wire

// ==== verilog/rgb2yuv.sv ====
//////////////////////////////////////////////////
// RGB to YCbCr conversion with a 2 cycle pipeline.
// The whole pipeline stalls on the downstream hold.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rgb2yuv (
    input  logic                   clk,
    input  logic                   rst_n,
    input  jisp_pixel_pkg::pixel_t rgb24,
    input  logic                   rgb24_valid,
    output logic                   rgb24_hold,
    input  logic                   frame_valid_in,
    input  logic                   line_valid_in,
    pixel_stream_if.src            out
);
    import jisp_pixel_pkg::*;

    logic       en;
    logic [1:0] valid_sr;
    logic [1:0] fv_sr;
    logic [1:0] lv_sr;
    sample_t    yuv_ch [3];

    assign en         = ~out.hold;
    assign rgb24_hold = out.hold;

    for (genvar ch = 0; ch < 3; ch++) begin : g_row
        color_matrix_row #(
            .CHANNEL (ch)
        ) u_row (
            .clk    (clk),
            .rst_n  (rst_n),
            .en     (en),
            .rgb    (rgb24),
            .result (yuv_ch[ch])
        );
    end

    // flags follow the matrix rows stage for stage.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_sr <= '0;
            fv_sr    <= '0;
            lv_sr    <= '0;
        end else if (en) begin
            valid_sr <= {valid_sr[0], rgb24_valid & frame_valid_in};
            fv_sr    <= {fv_sr[0], frame_valid_in};
            lv_sr    <= {lv_sr[0], line_valid_in};
        end
    end

    assign out.data        = {yuv_ch[2], yuv_ch[1], yuv_ch[0]};
    assign out.lanes       = {3{valid_sr[1]}};
    assign out.frame_valid = fv_sr[1];
    assign out.line_valid  = lv_sr[1];
    // last pixel is the one just ahead of the frame_valid fall.
    assign out.eof         = valid_sr[1] & fv_sr[1] & ~fv_sr[0];
endmodule

`default_nettype wire

// ==== verilog/subsample.sv ====
//////////////////////////////////////////////////
// 4:2:0 chroma decimation, one register stage.
// Chroma comes from pixel pairs on even lines;
// odd lines pass Y only.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module subsample (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [jisp_frame_pkg::X_W-1:0] x_size_m1,
    pixel_stream_if.snk                   in,
    pixel_stream_if.src                   out
);
    import jisp_pixel_pkg::*;
    import jisp_frame_pkg::*;

    logic [X_W-1:0] x_cnt;
    logic           odd_line;
    logic           take;
    logic           chroma_beat;
    sample_t        cb_even;
    sample_t        cr_even;
    logic [DW:0]    cb_sum;
    logic [DW:0]    cr_sum;
    pixel_t         data_q;
    logic [2:0]     lanes_q;
    logic           fv_q;
    logic           lv_q;
    logic           eof_q;

    assign in.hold     = out.hold;
    assign take        = in.lanes[CH_Y] & ~in.hold;
    assign chroma_beat = ~odd_line & x_cnt[0];
    assign cb_sum      = {1'b0, cb_even} + {1'b0, in.data[CH_CB]};
    assign cr_sum      = {1'b0, cr_even} + {1'b0, in.data[CH_CR]};

    // pixel and line position within the frame.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_cnt    <= '0;
            odd_line <= 1'b0;
        end else if (!in.hold) begin
            if (!in.frame_valid) begin
                x_cnt    <= '0;
                odd_line <= 1'b0;
            end else if (!in.line_valid) begin
                x_cnt <= '0;
            end else if (in.lanes[CH_Y]) begin
                if (x_cnt == x_size_m1) begin
                    x_cnt    <= '0;
                    odd_line <= ~odd_line;
                end else begin
                    x_cnt <= x_cnt + 1'b1;
                end
            end
        end
    end

    // left pixel of each chroma pair.
    always_ff @(posedge clk) begin
        if (take && !odd_line && !x_cnt[0]) begin
            cb_even <= in.data[CH_CB];
            cr_even <= in.data[CH_CR];
        end
    end

    always_ff @(posedge clk) begin
        if (!out.hold) begin
            data_q[CH_Y]  <= in.data[CH_Y];
            data_q[CH_CB] <= cb_sum[DW:1];
            data_q[CH_CR] <= cr_sum[DW:1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lanes_q <= '0;
            fv_q    <= 1'b0;
            lv_q    <= 1'b0;
            eof_q   <= 1'b0;
        end else if (!out.hold) begin
            lanes_q <= in.lanes[CH_Y] ? {{2{chroma_beat}}, 1'b1} : 3'b000;
            fv_q    <= in.frame_valid;
            lv_q    <= in.line_valid;
            eof_q   <= in.eof & in.lanes[CH_Y];
        end
    end

    assign out.data        = data_q;
    assign out.lanes       = lanes_q;
    assign out.frame_valid = fv_q;
    assign out.line_valid  = lv_q;
    assign out.eof         = eof_q;
endmodule

`default_nettype wire

// ==== verilog/mcu_buffer.sv ====
//////////////////////////////////////////////////
// Stripe buffer that turns raster 4:2:0 samples
// into 8x8 block rows. Fills 16 lines, then holds
// the input while it drains MCU by MCU.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mcu_buffer (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [jisp_frame_pkg::X_W-1:0]       x_size_m1,
    pixel_stream_if.snk                          in,
    output logic signed [jisp_pixel_pkg::DW-1:0] di [jisp_frame_pkg::BLK_SIZE-1:0],
    output logic                                 di_valid,
    input  logic                                 di_hold,
    output logic [2:0]                           di_cnt
);
    import jisp_pixel_pkg::*;
    import jisp_frame_pkg::*;

    // eight banks, one per sample of a block row.
    sample_t y_mem  [BLK_SIZE][1 << Y_ADDR_W];
    sample_t cb_mem [BLK_SIZE][1 << C_ADDR_W];
    sample_t cr_mem [BLK_SIZE][1 << C_ADDR_W];

    logic [X_W-1:0]       wx;
    logic [MCU_LOG-1:0]   wy;
    logic                 take_y;
    logic                 take_c;
    logic                 line_end;
    logic                 stripe_end;
    logic                 hold_q;
    logic                 issue_q;
    logic                 rd_go;
    logic                 rd_last;
    logic                 di_last;
    logic [MCU_COL_W-1:0] mx;
    logic [2:0]           blk;
    logic [BLK_LOG-1:0]   row;
    logic [Y_ADDR_W-1:0]  y_raddr;
    logic [C_ADDR_W-1:0]  c_raddr;
    sample_t              rd_row [BLK_SIZE];

    //////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////
    assign in.hold    = hold_q;
    assign take_y     = in.lanes[CH_Y] & ~hold_q;
    assign take_c     = in.lanes[CH_CB] & ~hold_q;
    assign line_end   = take_y & (wx == x_size_m1);
    assign stripe_end = (line_end & (&wy)) | (take_y & in.eof);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wx <= '0;
            wy <= '0;
        end else if (!hold_q && !in.frame_valid) begin
            wx <= '0;
            wy <= '0;
        end else if (take_y) begin
            wx <= (line_end || in.eof) ? '0 : wx + 1'b1;
            if (in.eof) begin
                wy <= '0;
            end else if (line_end) begin
                wy <= wy + 1'b1;
            end
        end
    end

    // chroma arrives on odd pixels of even lines.
    always_ff @(posedge clk) begin
        if (take_y) begin
            y_mem[wx[BLK_LOG-1:0]][{wy, wx[X_W-1:BLK_LOG]}] <= in.data[CH_Y];
        end
        if (take_c) begin
            cb_mem[wx[BLK_LOG:1]][{wy[MCU_LOG-1:1], wx[X_W-1:MCU_LOG]}] <= in.data[CH_CB];
            cr_mem[wx[BLK_LOG:1]][{wy[MCU_LOG-1:1], wx[X_W-1:MCU_LOG]}] <= in.data[CH_CR];
        end
    end

    //////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////
    assign rd_go   = issue_q & (~di_valid | ~di_hold);
    assign rd_last = (row == BLK_LOG'(BLK_SIZE - 1))
                   & (blk == 3'(BLOCKS_PER_MCU - 1))
                   & (mx == x_size_m1[X_W-1:MCU_LOG]);

    // blk bit 0 picks the right half, bit 1 the lower half.
    assign y_raddr = {blk[1], row, mx, blk[0]};
    assign c_raddr = {row, mx};

    always_comb begin
        for (int k = 0; k < BLK_SIZE; k++) begin
            case (blk)
                3'd4:    rd_row[k] = cb_mem[k][c_raddr];
                3'd5:    rd_row[k] = cr_mem[k][c_raddr];
                default: rd_row[k] = y_mem[k][y_raddr];
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_q   <= 1'b0;
            issue_q  <= 1'b0;
            mx       <= '0;
            blk      <= '0;
            row      <= '0;
            di_valid <= 1'b0;
            di_last  <= 1'b0;
            di_cnt   <= '0;
        end else begin
            if (stripe_end) begin
                hold_q  <= 1'b1;
                issue_q <= 1'b1;
            end
            if (rd_go) begin
                di_valid <= 1'b1;
                di_last  <= rd_last;
                di_cnt   <= row;
                row      <= row + 1'b1;
                if (rd_last) begin
                    issue_q <= 1'b0;
                end
                if (row == BLK_LOG'(BLK_SIZE - 1)) begin
                    if (blk == 3'(BLOCKS_PER_MCU - 1)) begin
                        blk <= '0;
                        mx  <= (mx == x_size_m1[X_W-1:MCU_LOG]) ? '0 : mx + 1'b1;
                    end else begin
                        blk <= blk + 1'b1;
                    end
                end
            end else if (!di_hold) begin
                di_valid <= 1'b0;
            end
            // stripe drained, let the next one in.
            if (di_valid && !di_hold && di_last) begin
                hold_q <= 1'b0;
            end
        end
    end

    // level shift to signed.
    always_ff @(posedge clk) begin
        if (rd_go) begin
            for (int k = 0; k < BLK_SIZE; k++) begin
                di[k] <= $signed(rd_row[k] - 8'd128);
            end
        end
    end
endmodule

`default_nettype wire

// ==== verilog/jisp.sv ====
//////////////////////////////////////////////////
// JPEG ISP front end: RGB in, level shifted 8x8
// block rows out in MCU order.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module jisp (
    input  jisp_pixel_pkg::sample_t               rgb24 [2:0],
    input  logic                                  rgb24_valid,
    output logic                                  rgb24_hold,
    input  logic                                  frame_valid_in,
    input  logic                                  line_valid_in,

    output logic signed [jisp_pixel_pkg::DW-1:0]  di [jisp_frame_pkg::BLK_SIZE-1:0],
    output logic                                  di_valid,
    input  logic                                  di_hold,
    output logic [2:0]                            di_cnt,

    input  logic [jisp_frame_pkg::X_W-1:0]        x_size_m1,
    // used by the encoder header logic.
    input  logic [jisp_frame_pkg::Y_W-1:0]        y_size_m1,
    input  logic                                  clk,
    input  logic                                  rst_n
);
    import jisp_pixel_pkg::*;

    pixel_t rgb_px;

    pixel_stream_if #(.payload_t(pixel_t)) yuv_s ();
    pixel_stream_if #(.payload_t(pixel_t)) yuv420_s ();

    assign rgb_px = {rgb24[2], rgb24[1], rgb24[0]};

    rgb2yuv u_rgb2yuv (
        .clk            (clk),
        .rst_n          (rst_n),
        .rgb24          (rgb_px),
        .rgb24_valid    (rgb24_valid),
        .rgb24_hold     (rgb24_hold),
        .frame_valid_in (frame_valid_in),
        .line_valid_in  (line_valid_in),
        .out            (yuv_s.src)
    );

    subsample u_subsample (
        .clk       (clk),
        .rst_n     (rst_n),
        .x_size_m1 (x_size_m1),
        .in        (yuv_s.snk),
        .out       (yuv420_s.src)
    );

    mcu_buffer u_mcu_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .x_size_m1 (x_size_m1),
        .in        (yuv420_s.snk),
        .di        (di),
        .di_valid  (di_valid),
        .di_hold   (di_hold),
        .di_cnt    (di_cnt)
    );
endmodule

`default_nettype wire

// ==== sim/clock_gen.sv ====
//////////////////////////////////////////////////
// Clock and reset source for the testbench.
// 20 ns clock, rst_n held low for five cycles.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 5
)(
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release away from the rising edge.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end
endmodule

`default_nettype wire

// ==== sim/jisp_tb.sv ====
//////////////////////////////////////////////////
// Directed testbench for the JPEG ISP front end.
// Sends RGB frames, collects block rows and checks
// them against a software model of the pipeline.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module jisp_tb;
    import jisp_frame_pkg::*;

    localparam int TIMEOUT = 20000;

    logic                  clk;
    logic                  rst_n;
    logic [7:0]            rgb24 [2:0];
    logic                  rgb24_valid;
    logic                  rgb24_hold;
    logic                  frame_valid_in;
    logic                  line_valid_in;
    logic signed [7:0]     di [7:0];
    logic                  di_valid;
    logic                  di_hold;
    logic [2:0]            di_cnt;
    logic [X_W-1:0]        x_size_m1;
    logic [Y_W-1:0]        y_size_m1;

    // R/G/B of each pixel of the frame in raster order.
    logic [7:0]            pix [1024][3];
    int                    frame_w;
    int                    frame_h;
    int                    checks;
    int                    errors;
    int                    hold_seen;

    clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    jisp uut (
        .rgb24          (rgb24),
        .rgb24_valid    (rgb24_valid),
        .rgb24_hold     (rgb24_hold),
        .frame_valid_in (frame_valid_in),
        .line_valid_in  (line_valid_in),
        .di             (di),
        .di_valid       (di_valid),
        .di_hold        (di_hold),
        .di_cnt         (di_cnt),
        .x_size_m1      (x_size_m1),
        .y_size_m1      (y_size_m1),
        .clk            (clk),
        .rst_n          (rst_n)
    );

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // JPEG YCbCr in 8 bit fixed point with floor and clamp.
    function automatic int ycc(input int x, input int y, input int ch);
        int r;
        int g;
        int b;
        int s;
        r = int'(pix[y * frame_w + x][0]);
        g = int'(pix[y * frame_w + x][1]);
        b = int'(pix[y * frame_w + x][2]);
        case (ch)
            0:       s = (77 * r + 150 * g + 29 * b) >>> 8;
            1:       s = ((-43 * r - 85 * g + 128 * b) >>> 8) + 128;
            default: s = ((128 * r - 107 * g - 21 * b) >>> 8) + 128;
        endcase
        if (s < 0) begin
            s = 0;
        end else if (s > 255) begin
            s = 255;
        end
        return s;
    endfunction

    // sample j of row k in block b of MCU column mx in stripe s.
    function automatic logic signed [7:0] expect_sample(input int s, input int mx,
                                                        input int b, input int k,
                                                        input int j);
        int x;
        int y;
        int v;
        if (b < 4) begin
            x = mx * 16 + (b % 2) * 8 + j;
            y = s * 16 + (b / 2) * 8 + k;
            v = ycc(x, y, 0);
        end else begin
            // chroma from the horizontal pair on the even line.
            x = mx * 16 + 2 * j;
            y = s * 16 + 2 * k;
            v = (ycc(x, y, b - 3) + ycc(x + 1, y, b - 3)) / 2;
        end
        return 8'(v - 128);
    endfunction

    //////////////////////////////////////////////////
    // stimulus and checking
    //////////////////////////////////////////////////

    task automatic fill_const(input logic [7:0] r, input logic [7:0] g, input logic [7:0] b);
        for (int i = 0; i < 1024; i++) begin
            pix[i][0] = r;
            pix[i][1] = g;
            pix[i][2] = b;
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < 1024; i++) begin
            for (int c = 0; c < 3; c++) begin
                pix[i][c] = 8'($urandom());
            end
        end
    endtask

    task automatic send_frame(input int gap_pct);
        int   idx;
        int   cycles;
        int   n;
        logic blank;
        logic stalled;
        n       = frame_w * frame_h;
        idx     = 0;
        cycles  = 0;
        blank   = 1'b0;
        stalled = 1'b0;
        @(posedge clk);
        frame_valid_in <= 1'b1;
        while (idx < n && cycles < TIMEOUT) begin
            // a held beat stays on the port unchanged.
            if (!stalled) begin
                if (blank) begin
                    line_valid_in <= 1'b0;
                    rgb24_valid   <= 1'b0;
                    blank = 1'b0;
                end else begin
                    line_valid_in <= 1'b1;
                    if ($urandom_range(99) < gap_pct) begin
                        rgb24_valid <= 1'b0;
                    end else begin
                        rgb24[0]    <= pix[idx][0];
                        rgb24[1]    <= pix[idx][1];
                        rgb24[2]    <= pix[idx][2];
                        rgb24_valid <= 1'b1;
                    end
                end
            end
            @(negedge clk);
            stalled = rgb24_hold;
            if (rgb24_hold) begin
                hold_seen++;
            end
            if (rgb24_valid && !rgb24_hold) begin
                idx++;
                if (idx % frame_w == 0) begin
                    blank = 1'b1;
                end
            end
            cycles++;
            @(posedge clk);
        end
        frame_valid_in <= 1'b0;
        line_valid_in  <= 1'b0;
        rgb24_valid    <= 1'b0;
        if (idx < n) begin
            errors++;
            $display("Timeout: input accepted only %0d of %0d pixels", idx, n);
        end
    endtask

    task automatic check_beat(input int n);
        int                per_stripe;
        int                s;
        int                mx;
        int                b;
        int                k;
        logic signed [7:0] want;
        per_stripe = (frame_w / 16) * 48;
        s  = n / per_stripe;
        mx = (n % per_stripe) / 48;
        b  = (n % 48) / 8;
        k  = n % 8;
        checks++;
        if (di_cnt != 3'(k)) begin
            errors++;
            $display("Mismatch at %0t: beat %0d di_cnt %0d, expected %0d",
                     $time, n, di_cnt, k);
        end
        for (int j = 0; j < 8; j++) begin
            want = expect_sample(s, mx, b, k, j);
            checks++;
            if (di[j] != want) begin
                errors++;
                $display("Mismatch at %0t: beat %0d block %0d sample %0d got %0d, expected %0d",
                         $time, n, b, j, di[j], want);
            end
        end
    endtask

    task automatic collect_beats(input int n_beats, input int hold_pct);
        int got;
        int cycles;
        got    = 0;
        cycles = 0;
        while (got < n_beats && cycles < TIMEOUT) begin
            @(posedge clk);
            di_hold <= ($urandom_range(99) < hold_pct);
            @(negedge clk);
            // a beat moves on the next rising edge.
            if (di_valid && !di_hold) begin
                check_beat(got);
                got++;
            end
            cycles++;
        end
        @(posedge clk);
        di_hold <= 1'b0;
        if (got < n_beats) begin
            errors++;
            $display("Timeout: received only %0d of %0d block rows", got, n_beats);
        end
    endtask

    // no stray beats and the input side open again.
    task automatic check_idle(input int n_cycles);
        int extra;
        extra = 0;
        repeat (n_cycles) begin
            @(negedge clk);
            if (di_valid) begin
                extra++;
            end
        end
        checks++;
        if (extra != 0) begin
            errors++;
            $display("Output kept sending after the frame: %0d extra cycles", extra);
        end
        checks++;
        if (rgb24_hold) begin
            errors++;
            $display("Input hold still high after the frame drained");
        end
    endtask

    task automatic run_frame(input int w, input int h, input int gap_pct, input int hold_pct);
        int n_beats;
        frame_w   = w;
        frame_h   = h;
        hold_seen = 0;
        n_beats   = (w / 16) * (h / 16) * 48;
        @(posedge clk);
        x_size_m1 <= X_W'(w - 1);
        y_size_m1 <= Y_W'(h - 1);
        fork
            send_frame(gap_pct);
            collect_beats(n_beats, hold_pct);
        join
        check_idle(20);
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    task automatic reset_state();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        @(negedge clk);
        checks++;
        if (rst_n !== 1'b1) begin
            errors++;
            $display("Reset never released");
        end
        checks++;
        if (di_valid !== 1'b0 || rgb24_hold !== 1'b0) begin
            errors++;
            $display("Mismatch at %0t: di_valid %b rgb24_hold %b after reset",
                     $time, di_valid, rgb24_hold);
        end
    endtask

    task automatic constant_colors();
        fill_const(8'd0, 8'd0, 8'd0);
        run_frame(16, 16, 0, 0);
        fill_const(8'd255, 8'd255, 8'd255);
        run_frame(16, 16, 0, 0);
        fill_const(8'd255, 8'd0, 8'd0);
        run_frame(16, 16, 0, 0);
    endtask

    task automatic random_frame();
        fill_random();
        run_frame(16, 16, 0, 0);
    endtask

    // even lines vary per pixel while odd lines carry something else.
    task automatic chroma_rule();
        int p;
        for (int y = 0; y < 16; y++) begin
            for (int x = 0; x < 16; x++) begin
                p = y * 16 + x;
                if (y % 2 == 0) begin
                    pix[p][0] = 8'(x * 16 + y * 3);
                    pix[p][1] = 8'(255 - x * 9);
                    pix[p][2] = 8'(x * x + 40);
                end else begin
                    pix[p][0] = 8'(200 - x * 5);
                    pix[p][1] = 8'(x * 7);
                    pix[p][2] = 8'(255 - y * 11);
                end
            end
        end
        run_frame(16, 16, 0, 0);
    endtask

    task automatic two_columns();
        fill_random();
        run_frame(32, 16, 0, 40);
    endtask

    task automatic two_stripes();
        fill_random();
        run_frame(16, 32, 30, 0);
        checks++;
        if (hold_seen == 0) begin
            errors++;
            $display("Input hold never rose during a two stripe frame");
        end
    endtask

    initial begin
        void'($urandom(32'hb02d96ce));
        checks         = 0;
        errors         = 0;
        hold_seen      = 0;
        frame_w        = 16;
        frame_h        = 16;
        rgb24[0]       = 8'd0;
        rgb24[1]       = 8'd0;
        rgb24[2]       = 8'd0;
        rgb24_valid    = 1'b0;
        frame_valid_in = 1'b0;
        line_valid_in  = 1'b0;
        di_hold        = 1'b0;
        x_size_m1      = '0;
        y_size_m1      = '0;

        reset_state();
        constant_colors();
        random_frame();
        chroma_rule();
        two_columns();
        two_stripes();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

// ==== all.f ====
verilog/jisp_pixel_pkg.sv
verilog/jisp_frame_pkg.sv
verilog/pixel_stream_if.sv
verilog/color_matrix_row.sv
verilog/rgb2yuv.sv
verilog/subsample.sv
verilog/mcu_buffer.sv
verilog/jisp.sv
sim/clock_gen.sv
sim/jisp_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= jisp_tb
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG) || ! grep -q "Testbench passed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
